// ==== Makefile ====
TOP = ccm_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o ccm_sim
	@out="$$(./obj_dir/ccm_sim 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== ccm_agu.sv ====
module ccm_agu (
   input  logic                             clk,
   input  logic                             rst_l,
   input  logic                             req_valid,
   input  ccm_pkg::ccm_op_e                 req_op,
   input  logic [31:0]                      rs1,
   input  logic [11:0]                      offset,   // signed
   input  logic [ecc_pkg::DATA_W-1:0]       wdata,
   output logic                             s1_valid,
   output ccm_pkg::ccm_op_e                 s1_op,
   output logic [ccm_pkg::IDX_W-1:0]        s1_idx,
   output logic [ecc_pkg::DATA_W-1:0]       s1_wdata,
   output logic                             s1_in_range
);

   logic        cout;
   logic        sign;
   logic [31:12] rs1_inc;
   logic [31:12] rs1_dec;
   logic [31:0] addr;
   logic        in_range;

   // low 12 bits add directly and the carry with the offset sign picks the upper half
   assign {cout, addr[11:0]} = {1'b0, rs1[11:0]} + {1'b0, offset};
   assign sign    = offset[11];
   assign rs1_inc = rs1[31:12] + 20'd1;
   assign rs1_dec = rs1[31:12] - 20'd1;

   assign addr[31:12] = ({20{sign ~^ cout}}  & rs1[31:12]) |
                        ({20{~sign & cout}}  & rs1_inc) |
                        ({20{sign & ~cout}}  & rs1_dec);

   assign in_range = (addr[31:ccm_pkg::MASK_BITS] ==
                      ccm_pkg::CCM_SADR[31:ccm_pkg::MASK_BITS]);

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         s1_valid    <= 1'b0;
         s1_op       <= ccm_pkg::OP_READ;
         s1_in_range <= 1'b0;
      end else begin
         s1_valid <= req_valid;
         if (req_valid) begin
            s1_op       <= req_op;
            s1_in_range <= in_range;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid) begin
         s1_idx   <= addr[ccm_pkg::IDX_W+1:2];   // byte offset dropped
         s1_wdata <= wdata;
      end
   end

endmodule

// ==== ccm_array.sv ====
module ccm_array (
   input  logic                        clk,
   input  logic                        rst_l,
   input  logic                        s1_valid,
   input  ccm_pkg::ccm_op_e            s1_op,
   input  logic [ccm_pkg::IDX_W-1:0]   s1_idx,
   input  logic [ecc_pkg::DATA_W-1:0]  s1_wdata,
   input  logic                        s1_in_range,
   output logic                        s2_valid,
   output ccm_pkg::ccm_op_e            s2_op,
   output logic                        s2_in_range,
   output logic [ecc_pkg::CW_W-1:0]    s2_cw
);

   logic [ecc_pkg::CW_W-1:0]  mem [ccm_pkg::DEPTH];
   logic [ecc_pkg::ECC_W-1:0] ecc;
   logic [ecc_pkg::CW_W-1:0]  wr_cw;
   logic [ecc_pkg::CW_W-1:0]  flip_mask;
   logic                      hit;

   ecc_secded_enc u_enc (
      .data (s1_wdata),
      .ecc  (ecc)
   );

   // interleave check bits at the power-of-two positions, parity on top
   assign wr_cw = {ecc[6], s1_wdata[31:26], ecc[5], s1_wdata[25:11], ecc[4],
                   s1_wdata[10:4], ecc[3], s1_wdata[3:1], ecc[2], s1_wdata[0], ecc[1:0]};

   always_comb begin
      for (int i = 0; i < ecc_pkg::CW_W; i++) begin
         flip_mask[i] = (s1_wdata[5:0] == 6'(i));   // 39..63 select nothing
      end
   end

   assign hit = s1_valid & s1_in_range;

   always_ff @(posedge clk) begin
      if (hit && s1_op == ccm_pkg::OP_WRITE) mem[s1_idx] <= wr_cw;
      if (hit && s1_op == ccm_pkg::OP_FLIP)  mem[s1_idx] <= mem[s1_idx] ^ flip_mask;
      s2_cw <= (hit && s1_op == ccm_pkg::OP_READ) ? mem[s1_idx] : '0;
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         s2_valid    <= 1'b0;
         s2_op       <= ccm_pkg::OP_READ;
         s2_in_range <= 1'b0;
      end else begin
         s2_valid    <= s1_valid;
         s2_op       <= s1_op;
         s2_in_range <= s1_in_range;
      end
   end

endmodule

// ==== ccm_asserts.sv ====
module ccm_asserts (
   input logic                  clk,
   input logic                  rst_l,
   input logic                  req_valid,
   input logic                  resp_valid,
   input ecc_pkg::ecc_status_e  resp_status,
   input logic                  resp_range_err
);

   // every request comes back after exactly three edges, and nothing else does
   a_latency : assert property (@(posedge clk) disable iff (!rst_l)
      resp_valid == $past(req_valid, 3))
      else $error("resp_valid does not match req_valid three cycles earlier");

   a_idle_status : assert property (@(posedge clk) disable iff (!rst_l)
      !resp_valid |-> resp_status == ecc_pkg::ECC_NONE)
      else $error("resp_status not ECC_NONE while no response is valid");

   // an out-of-range request never carries an ecc result
   a_range_status : assert property (@(posedge clk) disable iff (!rst_l)
      resp_range_err |-> resp_status == ecc_pkg::ECC_NONE)
      else $error("resp_range_err seen together with an ecc status");

endmodule

bind ccm_top ccm_asserts u_asserts (
   .clk            (clk),
   .rst_l          (rst_l),
   .req_valid      (req_valid),
   .resp_valid     (resp_valid),
   .resp_status    (resp_status),
   .resp_range_err (resp_range_err)
);

// ==== ccm_pkg.sv ====
package ccm_pkg;

   // memory map of the closely coupled memory
   localparam logic [31:0] CCM_SADR = 32'hF004_0000;   // base, aligned to the size
   localparam int CCM_SIZE_KB = 1;

   // low address bits that fall inside the ccm
   localparam int MASK_BITS = 10 + $clog2(CCM_SIZE_KB);

   // one 32-bit word per entry
   localparam int DEPTH = CCM_SIZE_KB * 1024 / 4;
   localparam int IDX_W = $clog2(DEPTH);

   // request opcodes
   typedef enum logic [1:0] {
      OP_READ  = 2'd0,
      OP_WRITE = 2'd1,
      OP_FLIP  = 2'd2    // invert one stored codeword bit
   } ccm_op_e;

endpackage

// ==== ccm_resp.sv ====
module ccm_resp (
   input  logic                        clk,
   input  logic                        rst_l,
   input  logic                        s2_valid,
   input  ccm_pkg::ccm_op_e            s2_op,
   input  logic                        s2_in_range,
   input  logic [ecc_pkg::CW_W-1:0]    s2_cw,
   output logic                        resp_valid,
   output logic [ecc_pkg::DATA_W-1:0]  resp_rdata,
   output ecc_pkg::ecc_status_e        resp_status,
   output logic                        resp_range_err
);

   logic [ecc_pkg::DATA_W-1:0] dec_data;
   ecc_pkg::ecc_status_e       dec_status;
   logic                       is_read;

   ecc_secded_dec u_dec (
      .cw     (s2_cw),
      .data   (dec_data),
      .status (dec_status)
   );

   // only a valid in-range read carries decoded data
   assign is_read = s2_valid & s2_in_range & (s2_op == ccm_pkg::OP_READ);

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         resp_valid     <= 1'b0;
         resp_status    <= ecc_pkg::ECC_NONE;
         resp_range_err <= 1'b0;
      end else begin
         resp_valid     <= s2_valid;
         resp_status    <= is_read ? dec_status : ecc_pkg::ECC_NONE;
         resp_range_err <= s2_valid & ~s2_in_range;
      end
   end

   always_ff @(posedge clk) begin
      resp_rdata <= is_read ? dec_data : '0;
   end

endmodule

// ==== ccm_tb.sv ====
module ccm_tb;

   localparam int TIMEOUT = 3000;   // roughly 780 requests plus reset and drain

   typedef struct packed {
      logic                       range_err;
      ecc_pkg::ecc_status_e       status;
      logic [ecc_pkg::DATA_W-1:0] rdata;
   } resp_t;

   logic                       clk;
   logic                       rst_l;
   logic                       req_valid;
   ccm_pkg::ccm_op_e           req_op;
   logic [31:0]                rs1;
   logic [11:0]                offset;
   logic [ecc_pkg::DATA_W-1:0] wdata;
   logic                       resp_valid;
   logic [ecc_pkg::DATA_W-1:0] resp_rdata;
   ecc_pkg::ecc_status_e       resp_status;
   logic                       resp_range_err;

   // shadow memory: word value and the set of flipped codeword bits
   logic [ecc_pkg::DATA_W-1:0] shadow_data  [ccm_pkg::DEPTH];
   logic [ecc_pkg::CW_W-1:0]   shadow_flips [ccm_pkg::DEPTH];

   resp_t exp_q[$];
   string name_q[$];
   int    issue_q[$];   // cycle count when each request was driven
   int    cycles = 0;
   string test_name;

   ccm_top u_ccm_top (
      .clk, .rst_l,
      .req_valid, .req_op, .rs1, .offset, .wdata,
      .resp_valid, .resp_rdata, .resp_status, .resp_range_err
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic fail_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic mismatch(string test, string field, logic [31:0] expv, logic [31:0] actv);
      $display("[ERROR] %s %s expected %h actual %h", test, field, expv, actv);
      fail_run();
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("run did not finish within %0d cycles", TIMEOUT);
         fail_run();
      end
   end

   // expected response, straight from the address, opcode and decode rules
   function automatic resp_t ref_access(ccm_pkg::ccm_op_e op, logic [31:0] base,
                                        logic [11:0] offs, logic [31:0] data);
      logic [31:0] addr;
      logic [7:0]  idx;
      resp_t       r;
      addr = base + {{20{offs[11]}}, offs};
      idx  = addr[9:2];
      r    = '0;
      if ((addr >> ccm_pkg::MASK_BITS) != (ccm_pkg::CCM_SADR >> ccm_pkg::MASK_BITS)) begin
         r.range_err = 1'b1;   // storage untouched
      end else if (op == ccm_pkg::OP_WRITE) begin
         shadow_data[idx]  = data;
         shadow_flips[idx] = '0;
      end else if (op == ccm_pkg::OP_FLIP) begin
         if (data[5:0] < 6'd39) shadow_flips[idx] ^= (ecc_pkg::CW_W)'(1) << data[5:0];
      end else begin
         r.rdata = shadow_data[idx];
         case ($countones(shadow_flips[idx]))
            0:       r.status = ecc_pkg::ECC_NONE;
            1:       r.status = ecc_pkg::ECC_SINGLE;
            default: r.status = ecc_pkg::ECC_DOUBLE;
         endcase
      end
      return r;
   endfunction

   task automatic send_req(ccm_pkg::ccm_op_e op, logic [31:0] base, logic [11:0] offs,
                           logic [31:0] data);
      @(negedge clk);
      req_valid = 1'b1;
      req_op    = op;
      rs1       = base;
      offset    = offs;
      wdata     = data;
      exp_q.push_back(ref_access(op, base, offs, data));
      name_q.push_back(test_name);
      issue_q.push_back(cycles);
   endtask

   // random signed offset, rs1 chosen so the sum lands on addr
   task automatic access_addr(ccm_pkg::ccm_op_e op, logic [31:0] addr, logic [31:0] data);
      logic [11:0] offs;
      offs = 12'($urandom);
      send_req(op, addr - {{20{offs[11]}}, offs}, offs, data);
   endtask

   task automatic access_word(ccm_pkg::ccm_op_e op, int idx, logic [31:0] data);
      access_addr(op, ccm_pkg::CCM_SADR + 32'(idx * 4) + $urandom_range(3), data);
   endtask

   task automatic idle(int n);
      repeat (n) begin
         @(negedge clk);
         req_valid = 1'b0;
      end
   endtask

   always @(negedge clk) begin : compare
      resp_t want;
      string nm;
      int    issued;
      if (rst_l && resp_valid) begin
         assert (exp_q.size() != 0) else begin
            $display("response arrived with no request outstanding");
            fail_run();
         end
         want   = exp_q.pop_front();
         nm     = name_q.pop_front();
         issued = issue_q.pop_front();
         assert (cycles - issued == 3)
            else mismatch(nm, "latency", 32'd3, 32'(cycles - issued));
         assert (resp_range_err == want.range_err)
            else mismatch(nm, "range_err", 32'(want.range_err), 32'(resp_range_err));
         assert (resp_status == want.status)
            else mismatch(nm, "status", 32'(want.status), 32'(resp_status));
         if (want.status != ecc_pkg::ECC_DOUBLE) begin
            assert (resp_rdata == want.rdata)
               else mismatch(nm, "rdata", want.rdata, resp_rdata);
         end
      end
   end

   initial begin
      logic [31:0] addr;
      int          pos;
      int          pos2;
      void'($urandom(32'hc19b));
      rst_l     = 1'b0;
      req_valid = 1'b0;
      req_op    = ccm_pkg::OP_READ;
      rs1       = '0;
      offset    = '0;
      wdata     = '0;
      test_name = "reset";
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_l = 1'b1;
      idle(4);   // any response here has no request behind it

      test_name = "write_read";
      for (int i = 0; i < ccm_pkg::DEPTH; i++) access_word(ccm_pkg::OP_WRITE, i, $urandom);
      for (int i = 0; i < ccm_pkg::DEPTH; i++) access_word(ccm_pkg::OP_READ, i, $urandom);
      idle(2);

      // positions 39 and up must leave the word alone
      test_name = "single_flip";
      for (pos = 0; pos < 45; pos++) begin
         access_word(ccm_pkg::OP_FLIP, pos, ($urandom & 32'hffff_ffc0) | 32'(pos));
         access_word(ccm_pkg::OP_READ, pos, $urandom);
         access_word(ccm_pkg::OP_WRITE, pos, $urandom);
         access_word(ccm_pkg::OP_READ, pos, $urandom);
      end
      idle(2);

      test_name = "double_flip";
      for (int k = 0; k < 8; k++) begin
         pos  = $urandom_range(38);
         pos2 = (pos + 1 + $urandom_range(37)) % 39;
         access_word(ccm_pkg::OP_FLIP, 100 + k, 32'(pos));
         access_word(ccm_pkg::OP_FLIP, 100 + k, 32'(pos2));
         access_word(ccm_pkg::OP_READ, 100 + k, $urandom);
         access_word(ccm_pkg::OP_WRITE, 100 + k, $urandom);
         access_word(ccm_pkg::OP_READ, 100 + k, $urandom);
      end
      idle(2);

      // low index bits match words 200..223, so a leak would show on readback
      test_name = "out_of_range";
      for (int k = 0; k < 24; k++) begin
         case (k % 3)
            0:       addr = ccm_pkg::CCM_SADR - 32'h400 + 32'((200 + k) * 4);
            1:       addr = ccm_pkg::CCM_SADR + 32'h400 * (1 + $urandom_range(15))
                            + 32'((200 + k) * 4);
            default: addr = ($urandom & 32'h000f_fc00) | 32'((200 + k) * 4);
         endcase
         access_addr(ccm_pkg::ccm_op_e'(k % 3), addr, $urandom);
      end
      for (int k = 0; k < 24; k++) access_word(ccm_pkg::OP_READ, 200 + k, $urandom);

      idle(1);
      while (exp_q.size() != 0) @(negedge clk);
      idle(4);
      $display("All tests passed");
      $finish;
   end

endmodule

// ==== ccm_top.sv ====
module ccm_top (
   input  logic                        clk,
   input  logic                        rst_l,
   input  logic                        req_valid,   // one-cycle strobe
   input  ccm_pkg::ccm_op_e            req_op,
   input  logic [31:0]                 rs1,
   input  logic [11:0]                 offset,
   input  logic [ecc_pkg::DATA_W-1:0]  wdata,
   output logic                        resp_valid,
   output logic [ecc_pkg::DATA_W-1:0]  resp_rdata,
   output ecc_pkg::ecc_status_e        resp_status,
   output logic                        resp_range_err
);

   // request stage
   logic                        s1_valid;
   ccm_pkg::ccm_op_e            s1_op;
   logic [ccm_pkg::IDX_W-1:0]   s1_idx;
   logic [ecc_pkg::DATA_W-1:0]  s1_wdata;
   logic                        s1_in_range;

   // storage stage
   logic                        s2_valid;
   ccm_pkg::ccm_op_e            s2_op;
   logic                        s2_in_range;
   logic [ecc_pkg::CW_W-1:0]    s2_cw;

   ccm_agu u_agu (
      .clk, .rst_l,
      .req_valid, .req_op, .rs1, .offset, .wdata,
      .s1_valid, .s1_op, .s1_idx, .s1_wdata, .s1_in_range
   );

   ccm_array u_array (
      .clk, .rst_l,
      .s1_valid, .s1_op, .s1_idx, .s1_wdata, .s1_in_range,
      .s2_valid, .s2_op, .s2_in_range, .s2_cw
   );

   ccm_resp u_resp (
      .clk, .rst_l,
      .s2_valid, .s2_op, .s2_in_range, .s2_cw,
      .resp_valid, .resp_rdata, .resp_status, .resp_range_err
   );

endmodule

// ==== ecc_pkg.sv ====
package ecc_pkg;

   // 32-bit SECDED word, six Hamming bits plus overall parity
   localparam int DATA_W = 32;
   localparam int ECC_W  = 7;
   localparam int CW_W   = DATA_W + ECC_W;   // 39, parity lives in the top bit

   // codeword bit map, hamming position p sits at cw[p-1]
   //   check bits at positions 1, 2, 4, 8, 16, 32
   //   data bits fill the remaining positions 3 to 38 in order
   //   cw[38] is the overall parity over everything below it

   // outcome of one decode
   typedef enum logic [1:0] {
      ECC_NONE   = 2'd0,   // clean word
      ECC_SINGLE = 2'd1,   // one bit bad, corrected
      ECC_DOUBLE = 2'd2    // two bits bad, data passed as is
   } ecc_status_e;

endpackage

// ==== ecc_secded_dec.sv ====
module ecc_secded_dec (
   input  logic [ecc_pkg::CW_W-1:0]   cw,
   output logic [ecc_pkg::DATA_W-1:0] data,
   output ecc_pkg::ecc_status_e        status
);

   logic [ecc_pkg::ECC_W-2:0] syn;      // hamming syndrome
   logic                      par_err;  // overall parity mismatch
   logic [ecc_pkg::CW_W-1:0]  err_mask;
   logic [ecc_pkg::CW_W-1:0]  fixed_cw;

   // syndrome bit k is the parity of every position with bit k set
   always_comb begin
      syn = '0;
      for (int p = 1; p < ecc_pkg::CW_W; p++) begin
         for (int k = 0; k < ecc_pkg::ECC_W - 1; k++) begin
            if (p[k]) syn[k] = syn[k] ^ cw[p-1];
         end
      end
   end

   assign par_err = ^cw;   // even over all 39 bits when clean

   // one-hot of the failing position
   // zero syndrome with a parity error means the parity bit itself
   always_comb begin
      for (int i = 0; i < ecc_pkg::CW_W - 1; i++) begin
         err_mask[i] = (syn == (ecc_pkg::ECC_W - 1)'(i + 1));
      end
      err_mask[ecc_pkg::CW_W-1] = (syn == '0);
   end

   assign fixed_cw = par_err ? (cw ^ err_mask) : cw;   // only correct single errors

   // pull the data bits back out of the non power-of-two positions
   assign data = {fixed_cw[37:32], fixed_cw[30:16], fixed_cw[14:8],
                  fixed_cw[6:4], fixed_cw[2]};

   always_comb begin
      if (par_err) begin
         status = ecc_pkg::ECC_SINGLE;
      end else if (syn != '0) begin
         status = ecc_pkg::ECC_DOUBLE;   // parity agrees but syndrome does not
      end else begin
         status = ecc_pkg::ECC_NONE;
      end
   end

endmodule

// ==== ecc_secded_enc.sv ====
module ecc_secded_enc (
   input  logic [ecc_pkg::DATA_W-1:0] data,
   output logic [ecc_pkg::ECC_W-1:0]  ecc
);

   int j;   // next data bit to place

   always_comb begin
      ecc = '0;
      j   = 0;
      // walk the hamming positions, skipping the check bit slots
      for (int p = 1; p < ecc_pkg::CW_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            for (int k = 0; k < ecc_pkg::ECC_W - 1; k++) begin
               if (p[k]) ecc[k] = ecc[k] ^ data[j];
            end
            j = j + 1;
         end
      end
      // overall parity covers data and the six check bits
      ecc[ecc_pkg::ECC_W-1] = (^data) ^ (^ecc[ecc_pkg::ECC_W-2:0]);
   end

endmodule

// ==== sim.f ====
ecc_pkg.sv
ccm_pkg.sv
ecc_secded_enc.sv
ecc_secded_dec.sv
ccm_agu.sv
ccm_array.sv
ccm_resp.sv
ccm_top.sv
ccm_asserts.sv
ccm_tb.sv
